//--- fb_box.f
hw/fb_box_pkg.sv
hw/display_timings.sv
hw/fb_draw_fsm.sv
hw/fb_bram.sv
hw/palette_ram.sv
hw/axil_regs.sv
hw/fb_scanout.sv
hw/fb_box_top.sv
sim/tb_fb_box.sv

//--- hw/axil_regs.sv
// AXI4-Lite slave for the command, status and palette registers
// command writes become a one-cycle pulse to the drawing engine
module axil_regs (
    input  logic clk_pix,
    input  logic rst,
    input  logic [fb_box_pkg::axil_addr_w-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [fb_box_pkg::axil_data_w-1:0] wdata,
    input  logic [fb_box_pkg::axil_data_w/8-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [fb_box_pkg::axil_addr_w-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [fb_box_pkg::axil_data_w-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    input  logic busy,
    output logic cmd_valid,
    output fb_box_pkg::draw_op_t cmd_op,
    output logic [fb_box_pkg::fb_data_w-1:0] cmd_cidx,
    output logic pal_we,
    output logic [fb_box_pkg::pal_addr_w-1:0] pal_waddr,
    output logic [fb_box_pkg::colour_w-1:0] pal_wdata,
    output logic [fb_box_pkg::pal_addr_w-1:0] pal_raddr,
    input  logic [fb_box_pkg::colour_w-1:0] pal_rdata
);
    import fb_box_pkg::*;

    logic w_fire, r_fire;
    logic busy_any;
    logic w_is_pal, w_op_ok, w_cmd_ok, w_pal_ok;
    logic r_is_pal;

    // address and data are taken in the same cycle
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign w_fire  = awready;
    assign arready = !rvalid;
    assign r_fire  = arvalid && arready;

    assign busy_any = busy || cmd_valid;  // covers the cycle before busy rises

    assign w_is_pal = (awaddr >= reg_pal_base) && (awaddr < reg_pal_base + 4 * pal_depth)
                      && (awaddr[1:0] == 2'b00);
    assign r_is_pal = (araddr >= reg_pal_base) && (araddr < reg_pal_base + 4 * pal_depth)
                      && (araddr[1:0] == 2'b00);
    assign w_op_ok  = (wdata[1:0] == op_fill) || (wdata[1:0] == op_box);
    assign w_cmd_ok = (awaddr == reg_cmd) && wstrb[0] && w_op_ok && !busy_any;
    assign w_pal_ok = w_is_pal && (&wstrb[1:0]);  // both colour bytes needed

    assign pal_we    = w_fire && w_pal_ok;
    assign pal_waddr = awaddr[2 +: pal_addr_w];
    assign pal_wdata = wdata[colour_w-1:0];
    assign pal_raddr = araddr[2 +: pal_addr_w];

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            bvalid    <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= w_fire && w_cmd_ok;
            if (w_fire) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (w_fire) begin
            bresp    <= (w_cmd_ok || w_pal_ok) ? resp_okay : resp_slverr;
            cmd_op   <= draw_op_t'(wdata[1:0]);
            cmd_cidx <= wdata[cmd_cidx_lsb +: fb_data_w];
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) rvalid <= 1'b0;
        else if (r_fire) rvalid <= 1'b1;
        else if (rready) rvalid <= 1'b0;
    end

    always_ff @(posedge clk_pix) begin
        if (r_fire) begin
            if (araddr == reg_status) begin
                rdata <= axil_data_w'(busy_any);
                rresp <= resp_okay;
            end else if (r_is_pal) begin
                rdata <= axil_data_w'(pal_rdata);
                rresp <= resp_okay;
            end else begin
                rdata <= '0;  // reg_cmd and holes
                rresp <= resp_slverr;
            end
        end
    end

endmodule

//--- hw/display_timings.sv
// raster counters and sync generation for 640x480
// frame pulses once per frame, at the first blanking line
module display_timings (
    input  logic clk_pix,
    input  logic rst,
    output logic signed [fb_box_pkg::coord_w-1:0] sx,
    output logic signed [fb_box_pkg::coord_w-1:0] sy,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic frame
);
    import fb_box_pkg::*;

    logic line_end;
    logic frame_end;

    assign line_end  = (sx == h_total - 1);
    assign frame_end = (sy == v_total - 1);

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // both syncs active low
    always_comb begin
        hsync = ~((sx >= h_active + h_front) && (sx < h_active + h_front + h_sync));
        vsync = ~((sy >= v_active + v_front) && (sy < v_active + v_front + v_sync));
    end

    always_comb begin
        de    = (sx < h_active) && (sy < v_active);
        frame = (sx == 0) && (sy == v_active);  // start of vertical blanking
    end

endmodule

//--- hw/fb_box_pkg.sv
// shared sizes, register map and enums for the framebuffer display subsystem
// modules pull these in with a wildcard import
package fb_box_pkg;

    // 640x480 at 60 Hz, counts in pixels and lines
    localparam int h_active = 640;
    localparam int h_front  = 16;
    localparam int h_sync   = 96;
    localparam int h_back   = 48;
    localparam int h_total  = 800;
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    localparam int v_total  = 525;
    localparam int coord_w  = 16;  // signed screen coordinates

    localparam int fb_width   = 160;
    localparam int fb_height  = 120;
    localparam int fb_pixels  = fb_width * fb_height;
    localparam int fb_addr_w  = 15;
    localparam int fb_data_w  = 4;   // colour index bits
    localparam int fb_scale   = 4;
    localparam int scan_delay = 3;   // stages ahead of the vga output register

    localparam int pal_depth  = 16;
    localparam int pal_addr_w = 4;
    localparam int colour_w   = 12;  // 4 bits each of red, green, blue

    localparam int axil_addr_w = 8;
    localparam int axil_data_w = 32;

    // register map, palette entry n sits at reg_pal_base + 4n
    localparam logic [axil_addr_w-1:0] reg_cmd      = 8'h00;
    localparam logic [axil_addr_w-1:0] reg_status   = 8'h04;
    localparam logic [axil_addr_w-1:0] reg_pal_base = 8'h40;
    localparam int cmd_cidx_lsb = 4;  // command word: opcode in 1:0, index in 7:4

    typedef enum logic [1:0] {op_fill = 2'd0, op_box = 2'd1} draw_op_t;

    typedef enum logic [2:0] {
        st_idle, st_wait_frame, st_fill, st_top, st_right, st_left, st_bottom
    } draw_state_t;

    typedef enum logic [1:0] {resp_okay = 2'b00, resp_slverr = 2'b10} axi_resp_t;

endpackage

//--- hw/fb_box_top.sv
// top level of the framebuffer display: AXI4-Lite control in, VGA out
// engine, framebuffer, palette and scanout all run on clk_pix
module fb_box_top (
    input  logic clk_pix,
    input  logic rst,
    input  logic [fb_box_pkg::axil_addr_w-1:0] awaddr,
    input  logic awvalid,
    output logic awready,
    input  logic [fb_box_pkg::axil_data_w-1:0] wdata,
    input  logic [fb_box_pkg::axil_data_w/8-1:0] wstrb,
    input  logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input  logic bready,
    input  logic [fb_box_pkg::axil_addr_w-1:0] araddr,
    input  logic arvalid,
    output logic arready,
    output logic [fb_box_pkg::axil_data_w-1:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input  logic rready,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);
    import fb_box_pkg::*;

    logic signed [coord_w-1:0] sx, sy;
    logic hsync, vsync, de, frame;
    logic busy, cmd_valid;
    draw_op_t cmd_op;
    logic [fb_data_w-1:0] cmd_cidx, fb_wdata, fb_rdata, scan_cidx;
    logic fb_we;
    logic [fb_addr_w-1:0] fb_waddr, fb_raddr;
    logic pal_we;
    logic [pal_addr_w-1:0] pal_waddr, pal_raddr;
    logic [colour_w-1:0] pal_wdata, pal_rdata, scan_colr;

    display_timings i_timings (
        .clk_pix, .rst, .sx, .sy, .hsync, .vsync, .de, .frame
    );

    fb_draw_fsm i_draw (
        .clk_pix, .rst, .frame, .cmd_valid, .cmd_op, .cmd_cidx,
        .busy, .fb_we, .fb_waddr, .fb_wdata
    );

    fb_bram i_bram (
        .clk_pix, .we(fb_we), .waddr(fb_waddr), .wdata(fb_wdata),
        .raddr(fb_raddr), .rdata(fb_rdata)
    );

    palette_ram i_palette (
        .clk_pix, .rst, .we(pal_we), .waddr(pal_waddr), .wdata(pal_wdata),
        .raddr_host(pal_raddr), .raddr_scan(scan_cidx),
        .rdata_host(pal_rdata), .rdata_scan(scan_colr)
    );

    axil_regs i_regs (
        .clk_pix, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .busy, .cmd_valid, .cmd_op, .cmd_cidx,
        .pal_we, .pal_waddr, .pal_wdata, .pal_raddr, .pal_rdata
    );

    fb_scanout i_scanout (
        .clk_pix, .rst, .sx, .sy, .hsync, .vsync, .de,
        .fb_rdata, .scan_colr, .fb_raddr, .scan_cidx,
        .vga_hsync, .vga_vsync, .vga_r, .vga_g, .vga_b
    );

endmodule

//--- hw/fb_bram.sv
// framebuffer storage, one colour index per pixel
// write port for the engine, registered read port for scanout
module fb_bram (
    input  logic clk_pix,
    input  logic we,
    input  logic [fb_box_pkg::fb_addr_w-1:0] waddr,
    input  logic [fb_box_pkg::fb_data_w-1:0] wdata,
    input  logic [fb_box_pkg::fb_addr_w-1:0] raddr,
    output logic [fb_box_pkg::fb_data_w-1:0] rdata
);
    import fb_box_pkg::*;

    logic [fb_data_w-1:0] mem [fb_pixels];

    // blank screen at start
    initial begin
        for (int i = 0; i < fb_pixels; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (we) mem[waddr] <= wdata;
        rdata <= mem[raddr];  // one cycle read
    end

endmodule

//--- hw/fb_draw_fsm.sv
// drawing engine: turns fill and box commands into framebuffer writes
// a command waits for the frame pulse, then writes one pixel per cycle
module fb_draw_fsm (
    input  logic clk_pix,
    input  logic rst,
    input  logic frame,
    input  logic cmd_valid,
    input  fb_box_pkg::draw_op_t cmd_op,
    input  logic [fb_box_pkg::fb_data_w-1:0] cmd_cidx,
    output logic busy,
    output logic fb_we,
    output logic [fb_box_pkg::fb_addr_w-1:0] fb_waddr,
    output logic [fb_box_pkg::fb_data_w-1:0] fb_wdata
);
    import fb_box_pkg::*;

    draw_state_t state;
    draw_op_t op;
    logic [fb_data_w-1:0] cidx;
    logic [$clog2(fb_width)-1:0] cnt;  // position along the current edge

    assign busy = (state != st_idle);

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state <= st_idle;
            fb_we <= 1'b0;
        end else begin
            case (state)
                st_idle:
                    if (cmd_valid) begin
                        state <= st_wait_frame;
                        op    <= cmd_op;
                        cidx  <= cmd_cidx;
                    end
                st_wait_frame:
                    if (frame) begin
                        fb_we    <= 1'b1;
                        fb_waddr <= '0;
                        fb_wdata <= cidx;
                        cnt      <= '0;
                        state    <= (op == op_fill) ? st_fill : st_top;
                    end
                st_fill:
                    if (fb_waddr == fb_addr_w'(fb_pixels - 1)) begin
                        fb_we <= 1'b0;
                        state <= st_idle;
                    end else begin
                        fb_waddr <= fb_waddr + 1'b1;
                    end
                st_top:  // whole top row
                    if (cnt == fb_width - 1) begin
                        cnt      <= '0;
                        fb_waddr <= fb_waddr + fb_addr_w'(fb_width);
                        state    <= st_right;
                    end else begin
                        cnt      <= cnt + 1'b1;
                        fb_waddr <= fb_waddr + 1'b1;
                    end
                st_right:  // rows 1 to the last, right column
                    if (cnt == fb_height - 2) begin
                        cnt      <= '0;
                        fb_waddr <= fb_addr_w'(fb_width);  // row 1, column 0
                        state    <= st_left;
                    end else begin
                        cnt      <= cnt + 1'b1;
                        fb_waddr <= fb_waddr + fb_addr_w'(fb_width);
                    end
                st_left:
                    if (cnt == fb_height - 2) begin
                        cnt      <= '0;
                        fb_waddr <= fb_waddr + 1'b1;  // bottom row from column 1
                        state    <= st_bottom;
                    end else begin
                        cnt      <= cnt + 1'b1;
                        fb_waddr <= fb_waddr + fb_addr_w'(fb_width);
                    end
                st_bottom:
                    if (cnt == fb_width - 2) begin
                        fb_we <= 1'b0;
                        state <= st_idle;
                    end else begin
                        cnt      <= cnt + 1'b1;
                        fb_waddr <= fb_waddr + 1'b1;
                    end
                default: begin
                    fb_we <= 1'b0;
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- hw/fb_scanout.sv
// scanout: scales screen coordinates to framebuffer addresses and
// drives the VGA pins four cycles behind the raster counters
module fb_scanout (
    input  logic clk_pix,
    input  logic rst,
    input  logic signed [fb_box_pkg::coord_w-1:0] sx,
    input  logic signed [fb_box_pkg::coord_w-1:0] sy,
    input  logic hsync,
    input  logic vsync,
    input  logic de,
    input  logic [fb_box_pkg::fb_data_w-1:0] fb_rdata,
    input  logic [fb_box_pkg::colour_w-1:0] scan_colr,
    output logic [fb_box_pkg::fb_addr_w-1:0] fb_raddr,
    output logic [fb_box_pkg::fb_data_w-1:0] scan_cidx,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);
    import fb_box_pkg::*;

    logic [scan_delay-1:0] de_sr, hsync_sr, vsync_sr;
    logic [colour_w-1:0] colr;

    // address only moves inside the active area
    always_ff @(posedge clk_pix) begin
        if (de) fb_raddr <= fb_addr_w'(fb_width * (sy / fb_scale) + sx / fb_scale);
    end

    // index register between BRAM and palette
    always_ff @(posedge clk_pix) begin
        scan_cidx <= fb_rdata;
    end

    // address, BRAM and index stages
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            de_sr    <= '0;
            hsync_sr <= '1;
            vsync_sr <= '1;
        end else begin
            de_sr    <= {de, de_sr[scan_delay-1:1]};
            hsync_sr <= {hsync, hsync_sr[scan_delay-1:1]};
            vsync_sr <= {vsync, vsync_sr[scan_delay-1:1]};
        end
    end

    assign colr = de_sr[0] ? scan_colr : '0;  // black in blanking

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            vga_hsync <= hsync_sr[0];
            vga_vsync <= vsync_sr[0];
            {vga_r, vga_g, vga_b} <= colr;
        end
    end

endmodule

//--- hw/palette_ram.sv
// colour lookup table, 16 entries of 12-bit rgb
// written by the host, read by both the host and the display
module palette_ram (
    input  logic clk_pix,
    input  logic rst,
    input  logic we,
    input  logic [fb_box_pkg::pal_addr_w-1:0] waddr,
    input  logic [fb_box_pkg::colour_w-1:0] wdata,
    input  logic [fb_box_pkg::pal_addr_w-1:0] raddr_host,
    input  logic [fb_box_pkg::pal_addr_w-1:0] raddr_scan,
    output logic [fb_box_pkg::colour_w-1:0] rdata_host,
    output logic [fb_box_pkg::colour_w-1:0] rdata_scan
);
    import fb_box_pkg::*;

    logic [colour_w-1:0] pal [pal_depth];

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            for (int i = 0; i < pal_depth; i++) begin
                pal[i] <= '0;  // all black
            end
        end else if (we) begin
            pal[waddr] <= wdata;
        end
    end

    // combinational lookups
    assign rdata_host = pal[raddr_host];
    assign rdata_scan = pal[raddr_scan];

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the fb_box testbench with Verilator.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f fb_box.f --top-module tb_fb_box -o tb_fb_box
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_fb_box
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0

//--- sim/tb_fb_box.sv
// testbench for the framebuffer display with random AXI4-Lite host traffic
// every pixel of quiet frames is checked on the VGA pins against a model
module tb_fb_box;
    timeunit 1ns;
    timeprecision 1ps;
    import fb_box_pkg::*;

    localparam int clk_period = 100;
    localparam int planned_frames = 14;  // draws wait up to a frame and checks take two
    localparam longint frame_ns = longint'(h_total) * v_total * clk_period;
    localparam int ack_limit = 1000;  // cycles allowed for one AXI handshake

    logic clk_pix;
    logic rst;
    logic [axil_addr_w-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [axil_data_w-1:0] wdata, rdata;
    logic [axil_data_w/8-1:0] wstrb;
    logic [1:0] bresp, rresp;
    logic vga_hsync, vga_vsync;
    logic [3:0] vga_r, vga_g, vga_b;

    // host view of the design
    logic [fb_data_w-1:0] fb_m [fb_height][fb_width];
    logic [colour_w-1:0] pal_m [pal_depth];
    logic draw_busy;

    // raster recovered from the sync outputs
    int px, py, hs_since, hs_low, vs_since, vs_low, frames_checked;
    logic hs_prev, vs_prev, h_locked, v_locked, check_req, checking;

    fb_box_top i_dut (.*);

    always #(clk_period / 2) clk_pix = ~clk_pix;

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("ERR %s exp 0x%0h got 0x%0h", name, exp, got);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic logic pal_hit(input logic [7:0] a);
        return a >= reg_pal_base && a < reg_pal_base + 4 * pal_depth && a[1:0] == 2'b00;
    endfunction

    function automatic logic [7:0] unmapped_addr();
        logic [7:0] a;
        do a = 8'($urandom); while (a == reg_cmd || a == reg_status || pal_hit(a));
        return a;
    endfunction

    function automatic logic [31:0] cmd_word(input logic [1:0] op, input logic [3:0] idx);
        return 32'(op) | (32'(idx) << cmd_cidx_lsb);
    endfunction

    function automatic logic [11:0] expected_colour(input int x, input int y);
        if (x < h_active && y < v_active) return pal_m[fb_m[y / fb_scale][x / fb_scale]];
        else return '0;  // blanking
    endfunction

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(negedge clk_pix);
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // bvalid marks the cycle after the write was taken
        n = 0;
        do begin
            @(negedge clk_pix);
            n++;
            if (n > ack_limit) abort_run("write was never accepted");
        end while (!bvalid);
        check_eq("awready", 0, awready);  // held response blocks the channel
        check_eq("wready", 0, wready);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp = bresp;  // bready held high clears it next edge
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(negedge clk_pix);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(negedge clk_pix);
            n++;
            if (n > ack_limit) abort_run("read address was never accepted");
        end
        @(negedge clk_pix);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk_pix);
            n++;
            if (n > ack_limit) abort_run("read data never arrived");
        end
        check_eq("arready", 0, arready);  // held read data blocks new addresses
        data = rdata;
        resp = rresp;
    endtask

    // response predicted from the register map and model updated on okay
    task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] exp_resp, resp;
        logic [3:0] idx;
        exp_resp = resp_slverr;
        if (addr == reg_cmd && data[1:0] <= 2'd1 && !draw_busy) exp_resp = resp_okay;
        if (pal_hit(addr)) exp_resp = resp_okay;
        axi_write(addr, data, resp);
        check_eq("bresp", exp_resp, resp);
        if (resp == resp_okay && addr == reg_cmd) begin
            draw_busy = 1'b1;
            idx = data[cmd_cidx_lsb +: fb_data_w];
            for (int y = 0; y < fb_height; y++) begin
                for (int x = 0; x < fb_width; x++) begin
                    if (data[1:0] == op_fill || x == 0 || x == fb_width - 1 ||
                        y == 0 || y == fb_height - 1) fb_m[y][x] = idx;
                end
            end
        end else if (resp == resp_okay) begin
            pal_m[(addr - reg_pal_base) >> 2] = data[colour_w-1:0];
        end
    endtask

    task automatic host_read(input logic [7:0] addr);
        logic [31:0] data;
        logic [1:0] resp;
        axi_read(addr, data, resp);
        if (pal_hit(addr)) begin
            check_eq("rresp", resp_okay, resp);
            check_eq("rdata", 32'(pal_m[(addr - reg_pal_base) >> 2]), data);
        end else begin
            check_eq("rresp", resp_slverr, resp);
            check_eq("rdata", 0, data);
        end
    endtask

    task automatic wait_idle();
        logic [31:0] data;
        logic [1:0] resp;
        do begin
            axi_read(reg_status, data, resp);
            check_eq("rresp", resp_okay, resp);
            check_eq("status_upper", 0, data >> 1);
        end while (data[0]);
        draw_busy = 1'b0;
    endtask

    task automatic check_next_frame();
        int n;
        n = frames_checked;
        check_req = 1'b1;
        wait (frames_checked == n + 1);
    endtask

    // sync timing and pixel checks sampled away from the rising edge
    always @(negedge clk_pix) begin
        if (!rst) begin
            px = px + 1;
            if (px == h_total) begin
                px = 0;
                py = (py + 1) % v_total;
            end
            hs_since++;
            vs_since++;
            if (!vga_hsync) hs_low++;
            if (!vga_vsync) vs_low++;
            if (hs_prev && !vga_hsync) begin
                if (h_locked) check_eq("hsync_period", h_total, hs_since);
                px = h_active + h_front;  // sample belongs to the first sync pixel
                hs_since = 0;
                h_locked = 1'b1;
            end
            if (!hs_prev && vga_hsync) begin
                check_eq("hsync_low", h_sync, hs_low);
                hs_low = 0;
            end
            if (vs_prev && !vga_vsync) begin
                if (v_locked) check_eq("vsync_period", h_total * v_total, vs_since);
                py = v_active + v_front;
                vs_since = 0;
                v_locked = 1'b1;
            end
            if (!vs_prev && vga_vsync) begin
                check_eq("vsync_low", h_total * v_sync, vs_low);
                vs_low = 0;
            end
            hs_prev = vga_hsync;
            vs_prev = vga_vsync;
            if (h_locked && v_locked && px == 0 && py == 0) begin
                if (checking) frames_checked++;
                checking  = check_req;
                check_req = 1'b0;
            end
            if (checking) check_eq("vga_rgb", expected_colour(px, py), {vga_r, vga_g, vga_b});
        end
    end

    initial begin
        #(planned_frames * frame_ns * 2);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        logic [7:0] addr;
        logic [31:0] data;
        logic [1:0] resp;
        logic [3:0] a, b;
        clk_pix = 1'b0;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        draw_busy = 1'b0;
        foreach (fb_m[y, x]) fb_m[y][x] = '0;
        foreach (pal_m[i]) pal_m[i] = '0;
        {px, py, hs_since, hs_low, vs_since, vs_low, frames_checked} = '0;
        {h_locked, v_locked, check_req, checking} = '0;
        hs_prev = 1'b1;
        vs_prev = 1'b1;
        void'($urandom(38));
        repeat (10) @(negedge clk_pix);
        rst = 1'b0;

        check_next_frame();  // blank screen out of reset
        for (int i = 0; i < pal_depth; i++) host_write(8'(reg_pal_base + 4 * i), $urandom);
        for (int i = 0; i < pal_depth; i++) host_read(8'(reg_pal_base + 4 * i));

        // holes, the command register and bad opcodes
        repeat (8) begin
            addr = unmapped_addr();
            host_write(addr, $urandom);
            host_read(addr);
        end
        host_read(reg_cmd);
        host_write(reg_status, $urandom);
        host_write(reg_cmd, cmd_word(2'd2, 4'($urandom)));
        host_write(reg_cmd, cmd_word(2'd3, 4'($urandom)));

        repeat (2) begin
            for (int i = 0; i < pal_depth; i++) host_write(8'(reg_pal_base + 4 * i), $urandom);
            host_write(reg_cmd, cmd_word(op_fill, 4'($urandom)));
            wait_idle();
            check_next_frame();
        end

        // box over a fill and a second command while the box is pending
        a = 4'($urandom);
        b = a + 4'($urandom_range(1, 15));
        host_write(reg_cmd, cmd_word(op_fill, a));
        wait_idle();
        host_write(reg_cmd, cmd_word(op_box, b));
        axi_read(reg_status, data, resp);
        check_eq("rresp", resp_okay, resp);
        check_eq("status", 1, data);
        host_write(reg_cmd, cmd_word(op_fill, b + 4'd1));
        wait_idle();
        check_next_frame();

        $display("Verification passed");
        $finish;
    end

endmodule
